//--- rtl/sha2_pkg.sv
package sha2_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [255:0] digest_t;
    typedef logic [5:0]   round_t;

    typedef enum logic {
        SHA_224 = 1'b0,
        SHA_256 = 1'b1
    } sha_mode_e;

    localparam word_t ROUND_K [64] = '{
        32'h428a_2f98, 32'h7137_4491, 32'hb5c0_fbcf, 32'he9b5_dba5,
        32'h3956_c25b, 32'h59f1_11f1, 32'h923f_82a4, 32'hab1c_5ed5,
        32'hd807_aa98, 32'h1283_5b01, 32'h2431_85be, 32'h550c_7dc3,
        32'h72be_5d74, 32'h80de_b1fe, 32'h9bdc_06a7, 32'hc19b_f174,
        32'he49b_69c1, 32'hefbe_4786, 32'h0fc1_9dc6, 32'h240c_a1cc,
        32'h2de9_2c6f, 32'h4a74_84aa, 32'h5cb0_a9dc, 32'h76f9_88da,
        32'h983e_5152, 32'ha831_c66d, 32'hb003_27c8, 32'hbf59_7fc7,
        32'hc6e0_0bf3, 32'hd5a7_9147, 32'h06ca_6351, 32'h1429_2967,
        32'h27b7_0a85, 32'h2e1b_2138, 32'h4d2c_6dfc, 32'h5338_0d13,
        32'h650a_7354, 32'h766a_0abb, 32'h81c2_c92e, 32'h9272_2c85,
        32'ha2bf_e8a1, 32'ha81a_664b, 32'hc24b_8b70, 32'hc76c_51a3,
        32'hd192_e819, 32'hd699_0624, 32'hf40e_3585, 32'h106a_a070,
        32'h19a4_c116, 32'h1e37_6c08, 32'h2748_774c, 32'h34b0_bcb5,
        32'h391c_0cb3, 32'h4ed8_aa4a, 32'h5b9c_ca4f, 32'h682e_6ff3,
        32'h748f_82ee, 32'h78a5_636f, 32'h84c8_7814, 32'h8cc7_0208,
        32'h90be_fffa, 32'ha450_6ceb, 32'hbef9_a3f7, 32'hc671_78f2
    };

    // index 0 is a, index 7 is h
    localparam word_t IV_224 [8] = '{
        32'hc105_9ed8,
        32'h367c_d507,
        32'h3070_dd17,
        32'hf70e_5939,
        32'hffc0_0b31,
        32'h6858_1511,
        32'h64f9_8fa7,
        32'hbefa_4fa4
    };

    localparam word_t IV_256 [8] = '{
        32'h6a09_e667,
        32'hbb67_ae85,
        32'h3c6e_f372,
        32'ha54f_f53a,
        32'h510e_527f,
        32'h9b05_688c,
        32'h1f83_d9ab,
        32'h5be0_cd19
    };

    // rotate right within one word
    function automatic word_t rotr(word_t x, int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

endpackage

//--- rtl/sha2_ctrl.sv
module sha2_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic in_valid_i,
    input  logic in_last_i,
    input  logic out_ready_i,
    input  logic load_done_i,
    input  logic rounds_done_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output logic init_o,
    output logic round_en_o,
    output logic expand_o,
    output logic update_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EXPAND,
        UPDATE,
        OUTPUT
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   last_q;
    logic   word15_acc;

    assign in_ready_o  = (state_q == LOAD);
    assign out_valid_o = (state_q == OUTPUT);
    assign init_o      = (state_q == IDLE) && in_valid_i; // iv load, word not taken
    assign expand_o    = (state_q == EXPAND);
    assign update_o    = (state_q == UPDATE);
    assign round_en_o  = (in_ready_o && in_valid_i) || expand_o;
    assign word15_acc  = in_ready_o && in_valid_i && load_done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (in_valid_i) state_d = LOAD;
            LOAD:    if (word15_acc) state_d = EXPAND;
            EXPAND:  if (rounds_done_i) state_d = UPDATE;
            UPDATE:  state_d = last_q ? OUTPUT : LOAD;
            OUTPUT:  if (out_ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            last_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (word15_acc) begin
                last_q <= in_last_i; // taken with word 15
            end
        end
    end

    a_no_dual_handshake: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(in_ready_o && out_valid_o));

    a_out_valid_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) out_valid_o && !out_ready_i |=> out_valid_o);

endmodule

//--- rtl/sha2_round_cnt.sv
module sha2_round_cnt import sha2_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   clr_i,
    input  logic   en_i,
    output round_t round_o,
    output logic   load_done_o,
    output logic   rounds_done_o
);

    assign load_done_o   = (round_o == round_t'(15));
    assign rounds_done_o = (round_o == round_t'(63));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            round_o <= '0;
        end else if (clr_i) begin
            round_o <= '0;
        end else if (en_i && !rounds_done_o) begin
            round_o <= round_o + round_t'(1); // holds at 63 until cleared
        end
    end

    // last round must be followed straight away by the chaining update
    a_clear_after_last: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) en_i && rounds_done_o |=> clr_i);

endmodule

//--- rtl/sha2_msg_sched.sv
module sha2_msg_sched import sha2_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  word_t data_i,
    input  logic  shift_i,
    input  logic  expand_i,
    output word_t w_o
);

    word_t win_q [16]; // win_q[15] is the newest word
    word_t data_be;
    word_t sig0;
    word_t sig1;
    word_t w_exp;

    // first message byte sits in bits 7:0
    assign data_be = {data_i[7:0], data_i[15:8], data_i[23:16], data_i[31:24]};

    assign sig0  = rotr(win_q[1], 7) ^ rotr(win_q[1], 18) ^ (win_q[1] >> 3);
    assign sig1  = rotr(win_q[14], 17) ^ rotr(win_q[14], 19) ^ (win_q[14] >> 10);
    assign w_exp = sig1 + win_q[9] + sig0 + win_q[0];

    assign w_o = expand_i ? w_exp : data_be;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                win_q[i] <= '0;
            end
        end else if (shift_i) begin
            for (int i = 0; i < 15; i++) begin
                win_q[i] <= win_q[i+1];
            end
            win_q[15] <= w_o;
        end
    end

endmodule

//--- rtl/sha2_compress.sv
module sha2_compress import sha2_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      init_i,
    input  logic      round_en_i,
    input  logic      update_i,
    input  sha_mode_e mode_i,
    input  round_t    round_i,
    input  word_t     w_i,
    output digest_t   digest_o
);

    sha_mode_e mode_q;
    word_t     h_q [8]; // chaining state H0..H7
    word_t     v_q [8]; // working variables a..h
    word_t     iv  [8];
    word_t     sum [8];

    word_t big_s0;
    word_t big_s1;
    word_t ch;
    word_t maj;
    word_t t1;
    word_t t2;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            iv[i]  = (mode_i == SHA_224) ? IV_224[i] : IV_256[i];
            sum[i] = h_q[i] + v_q[i];
        end
    end

    assign big_s0 = rotr(v_q[0], 2) ^ rotr(v_q[0], 13) ^ rotr(v_q[0], 22);
    assign big_s1 = rotr(v_q[4], 6) ^ rotr(v_q[4], 11) ^ rotr(v_q[4], 25);
    assign ch     = (v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]);
    assign maj    = (v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]);
    assign t1     = v_q[7] + big_s1 + ch + ROUND_K[round_i] + w_i;
    assign t2     = big_s0 + maj;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mode_q <= SHA_256;
        end else if (init_i) begin
            mode_q <= mode_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (init_i) begin
            for (int i = 0; i < 8; i++) begin
                h_q[i] <= iv[i];
                v_q[i] <= iv[i];
            end
        end else if (update_i) begin
            for (int i = 0; i < 8; i++) begin
                h_q[i] <= sum[i];
                v_q[i] <= sum[i]; // next block starts from new H
            end
        end else if (round_en_i) begin
            v_q[0] <= t1 + t2;
            v_q[1] <= v_q[0];
            v_q[2] <= v_q[1];
            v_q[3] <= v_q[2];
            v_q[4] <= v_q[3] + t1;
            v_q[5] <= v_q[4];
            v_q[6] <= v_q[5];
            v_q[7] <= v_q[6];
        end
    end

    // H0 in the top word, 224 drops H7 and zero fills
    assign digest_o = (mode_q == SHA_224) ?
        {32'h0, h_q[0], h_q[1], h_q[2], h_q[3], h_q[4], h_q[5], h_q[6]} :
        {h_q[0], h_q[1], h_q[2], h_q[3], h_q[4], h_q[5], h_q[6], h_q[7]};

endmodule

//--- rtl/sha2_core.sv
module sha2_core import sha2_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  sha_mode_e in_mode_i,
    input  logic      in_last_i,
    input  word_t     in_data_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,

    output digest_t   out_data_o,
    output logic      out_valid_o,
    input  logic      out_ready_i
);

    logic   init;
    logic   round_en;
    logic   expand;
    logic   update;
    round_t round;
    logic   load_done;
    logic   rounds_done;
    word_t  w;

    sha2_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_last_i     (in_last_i),
        .out_ready_i   (out_ready_i),
        .load_done_i   (load_done),
        .rounds_done_i (rounds_done),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .init_o        (init),
        .round_en_o    (round_en),
        .expand_o      (expand),
        .update_o      (update)
    );

    sha2_round_cnt i_round_cnt (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .clr_i         (init | update),
        .en_i          (round_en),
        .round_o       (round),
        .load_done_o   (load_done),
        .rounds_done_o (rounds_done)
    );

    sha2_msg_sched i_msg_sched (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .data_i   (in_data_i),
        .shift_i  (round_en),
        .expand_i (expand),
        .w_o      (w)
    );

    sha2_compress i_compress (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .init_i     (init),
        .round_en_i (round_en),
        .update_i   (update),
        .mode_i     (in_mode_i),
        .round_i    (round),
        .w_i        (w),
        .digest_o   (out_data_o)
    );

endmodule

//--- include/sha2_tb_model.svh
`ifndef SHA2_TB_MODEL_SVH
`define SHA2_TB_MODEL_SVH

function automatic word_t ror32(word_t x, int n);
    return (x >> n) | (x << (32 - n));
endfunction

// 0x80, zero fill, then the message length in bits, big-endian
function automatic void pad_message(input byte unsigned m[$], output byte unsigned p[$]);
    longint unsigned msg_bits;
    msg_bits = 64'(m.size()) * 8;
    p = m;
    p.push_back(8'h80);
    while (p.size() % 64 != 56)
        p.push_back(8'h00);
    for (int i = 7; i >= 0; i--)
        p.push_back(msg_bits[8*i +: 8]);
endfunction

function automatic digest_t model_digest(input sha_mode_e mode, input byte unsigned m[$]);
    byte unsigned p[$];
    word_t h [8];
    word_t v [8];
    word_t w [64];
    word_t s0, s1, t1, t2;
    pad_message(m, p);
    for (int i = 0; i < 8; i++)
        h[i] = (mode == SHA_224) ? IV_224[i] : IV_256[i];
    for (int b = 0; b < p.size(); b += 64) begin
        for (int t = 0; t < 16; t++)
            w[t] = {p[b+4*t], p[b+4*t+1], p[b+4*t+2], p[b+4*t+3]}; // big-endian words
        for (int t = 16; t < 64; t++) begin
            s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
            s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
            w[t] = w[t-16] + s0 + w[t-7] + s1;
        end
        v = h;
        for (int t = 0; t < 64; t++) begin
            s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
            s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
            t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + ROUND_K[t] + w[t];
            t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
            for (int i = 7; i > 0; i--)
                v[i] = v[i-1];
            v[4] = v[4] + t1; // e takes d + t1
            v[0] = t1 + t2;
        end
        for (int i = 0; i < 8; i++)
            h[i] = h[i] + v[i];
    end
    if (mode == SHA_224)
        return {32'h0, h[0], h[1], h[2], h[3], h[4], h[5], h[6]};
    return {h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]};
endfunction

`endif

//--- test/tb_sha2_core.sv
module tb_sha2_core import sha2_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int TOTAL_BLOCKS = 12; // worst case over all tests

    logic         clk_i = 1'b0;
    logic         rst_n_i;
    sha_mode_e    in_mode_i;
    word_t        in_data_i;
    digest_t      out_data_o;
    logic         in_last_i;
    logic         in_valid_i;
    logic         in_ready_o;
    logic         out_valid_o;
    logic         out_ready_i;
    logic [31:0]  lfsr = 32'hf4715b8b;
    int           errors = 0;
    int           failed = 0;
    int           tests = 0;
    int           mark = 0;
    byte unsigned msg [$];
    digest_t      got;
    int           lat_mid;
    int           lat_last;

    `include "sha2_tb_model.svh"

    sha2_core i_sha2_core (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic int unsigned rand_bits(int n);
        int unsigned r = 0;
        repeat (n) begin
            r = (r << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // galois step
        end
        return r;
    endfunction

    function automatic void fill_message(int len);
        msg.delete();
        repeat (len)
            msg.push_back(8'(rand_bits(8)));
    endfunction

    task automatic check_digest(string name, digest_t exp, digest_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report(string name);
        tests++;
        if (errors != mark)
            failed++;
        $display("%s: %s", name, (errors == mark) ? "passed" : "errors found");
        mark = errors;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
    endtask

    // counts edges before the flag goes high and returns just after the next edge
    task automatic count_edges(input bit want_out, output int n);
        logic seen;
        seen = 1'b0;
        n = 0;
        while (!seen) begin
            @(negedge clk_i);
            seen = want_out ? out_valid_o : in_ready_o;
            if (!seen)
                n++;
            @(posedge clk_i);
            #2;
        end
    endtask

    // feeds all padded words and returns with out_valid_o up
    task automatic send_message(string name, sha_mode_e mode, bit gaps);
        byte unsigned p[$];
        int n;
        pad_message(msg, p);
        lat_mid   = -1;
        in_mode_i = mode;
        for (int i = 0; i < p.size(); i += 4) begin
            repeat (gaps ? rand_bits(2) : 0) begin
                @(posedge clk_i);
                #2;
            end
            in_data_i  = {p[i+3], p[i+2], p[i+1], p[i]}; // first byte in bits 7:0
            in_last_i  = (i + 4 == p.size());
            in_valid_i = 1'b1;
            count_edges(1'b0, n);
            in_valid_i = 1'b0;
            check_count({name, " word wait"}, (i == 0) ? 1 : 0, n); // init cycle first
            if (i % 64 == 60 && !in_last_i)
                count_edges(1'b0, lat_mid); // wait for the next block
        end
        count_edges(1'b1, lat_last);
    endtask

    task automatic hash_message(string name, sha_mode_e mode, bit gaps, int hold);
        digest_t held;
        send_message(name, mode, gaps);
        held = out_data_o;
        repeat (hold) begin
            @(negedge clk_i);
            check_flag({name, " out_valid_o"}, 1'b1, out_valid_o);
            check_flag({name, " in_ready_o"}, 1'b0, in_ready_o);
            check_digest({name, " out_data_o held"}, held, out_data_o);
            @(posedge clk_i);
            #2;
        end
        out_ready_i = 1'b1;
        @(negedge clk_i);
        got = out_data_o;
        @(posedge clk_i);
        #2;
        out_ready_i = 1'b0;
        check_digest(name, model_digest(mode, msg), got);
    endtask

    task automatic sha256_abc();
        msg = '{8'h61, 8'h62, 8'h63};
        hash_message("sha256_abc", SHA_256, 1'b0, 0);
        check_digest("sha256_abc", {32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
                     32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad}, got);
        report("sha256_abc");
    endtask

    task automatic sha224_abc();
        msg = '{8'h61, 8'h62, 8'h63};
        hash_message("sha224_abc", SHA_224, 1'b0, 0);
        check_digest("sha224_abc top word", '0, {got[255:224], 224'h0});
        check_digest("sha224_abc", {32'h0, 32'h23097d22, 32'h3405d822, 32'h8642a477,
                     32'hbda255b3, 32'h2aadbce4, 32'hbda0b3f7, 32'he36c9da7}, got);
        report("sha224_abc");
    endtask

    task automatic two_block();
        fill_message(56); // padding spills into a second block
        hash_message("two_block", SHA_256, 1'b0, 0);
        fill_message(9);
        hash_message("two_block second", SHA_224, 1'b0, 0);
        report("two_block");
    endtask

    task automatic input_gaps();
        fill_message(int'(rand_bits(7)));
        hash_message("input_gaps", SHA_256, 1'b1, 0);
        report("input_gaps");
    endtask

    task automatic backpressure();
        fill_message(20);
        hash_message("backpressure", SHA_224, 1'b0, int'(rand_bits(4)));
        report("backpressure");
    endtask

    task automatic latency_reset();
        fill_message(3);
        send_message("latency_reset pending", SHA_256, 1'b0); // digest left waiting
        apply_reset();
        check_flag("latency_reset in_ready_o", 1'b0, in_ready_o);
        check_flag("latency_reset out_valid_o", 1'b0, out_valid_o);
        fill_message(56);
        hash_message("latency_reset", SHA_256, 1'b0, 0);
        check_count("latency_reset next block", 49, lat_mid);
        check_count("latency_reset out_valid_o", 49, lat_last);
        report("latency_reset");
    endtask

    initial begin
        #(CLK_PERIOD * (TOTAL_BLOCKS * 120 + 400));
        $display("timeout: tests still running after %0d cycles", TOTAL_BLOCKS * 120 + 400);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        in_mode_i   = SHA_256;
        in_last_i   = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        apply_reset();
        sha256_abc();
        sha224_abc();
        two_block();
        input_gaps();
        backpressure();
        latency_reset();
        $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
rtl/sha2_pkg.sv
rtl/sha2_ctrl.sv
rtl/sha2_round_cnt.sv
rtl/sha2_msg_sched.sv
rtl/sha2_compress.sv
rtl/sha2_core.sv
test/tb_sha2_core.sv

//--- Bender.yml
package:
  name: sha2_core

sources:
  - rtl/sha2_pkg.sv
  - rtl/sha2_ctrl.sv
  - rtl/sha2_round_cnt.sv
  - rtl/sha2_msg_sched.sv
  - rtl/sha2_compress.sv
  - rtl/sha2_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_sha2_core.sv
